// ==== design/dac_pkg.sv ====
`default_nettype none

package dac_pkg;

    // One stream word carries either a sample or a command.
    localparam int WORD_WIDTH = 16;

    localparam int GAIN_WIDTH = 14;

    // Gain is Q1.13, so this value passes samples through unscaled.
    localparam int GAIN_UNITY = 8192;

    typedef enum logic [1:0] {
        op_set_gain   = 2'd0,
        op_set_offset = 2'd1,
        op_clear      = 2'd2,
        op_none       = 2'd3
    } dac_op_e;

    // The meaning of value depends on op.
    // Gain is read unsigned, offset is read as signed DAC codes.
    typedef struct packed {
        dac_op_e               op;
        logic [GAIN_WIDTH-1:0] value;
    } dac_ctrl_t;

    // The stream tag selects which view of the word applies.
    typedef union packed {
        logic signed [WORD_WIDTH-1:0] sample;
        dac_ctrl_t                    ctrl;
    } dac_word_u;

endpackage

`default_nettype wire

// ==== design/dac_cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_cmd_decoder
    import dac_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [WORD_WIDTH-1:0]        s_tdata,
    input  logic                         s_tuser,
    input  logic                         s_tvalid,
    output logic                         s_tready,
    output logic signed [WORD_WIDTH-1:0] smp_data,
    output logic                         smp_valid,
    input  logic                         smp_ready,
    output logic [GAIN_WIDTH-1:0]        gain,
    output logic signed [GAIN_WIDTH-1:0] offset,
    output logic                         clr_req
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    dac_word_u word_in;
    logic      s_fire;
    logic      push;
    logic      pop;

    logic signed [WORD_WIDTH-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]         wr_ptr;
    logic [PTR_WIDTH-1:0]         rd_ptr;
    logic [PTR_WIDTH:0]           count;
    logic [PTR_WIDTH:0]           count_next;

    assign word_in = s_tdata;
    assign s_fire  = s_tvalid && s_tready;
    assign push    = s_fire && !s_tuser;
    assign pop     = smp_valid && smp_ready;

    assign smp_valid = (count != '0);
    assign smp_data  = fifo_mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Commands act on the cycle they are accepted.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gain    <= GAIN_WIDTH'(GAIN_UNITY);
            offset  <= '0;
            clr_req <= 1'b0;
        end else begin
            clr_req <= 1'b0;
            if (s_fire && s_tuser) begin
                case (word_in.ctrl.op)
                    op_set_gain:   gain <= word_in.ctrl.value;
                    op_set_offset: offset <= $signed(word_in.ctrl.value);
                    op_clear:      clr_req <= 1'b1;
                    op_none:       begin end
                    default:       begin end
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            s_tready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Ready follows the fill level one cycle ahead, so it never
            // admits a word the buffer has no room for.
            s_tready <= (count_next < FIFO_DEPTH);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= word_in.sample;
        end
    end

endmodule

`default_nettype wire

// ==== design/dac_scaler.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_scaler
    import dac_pkg::*;
#(
    parameter int DAC_WIDTH = 12
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic signed [WORD_WIDTH-1:0] smp_data,
    input  logic                         smp_valid,
    output logic                         smp_ready,
    input  logic [GAIN_WIDTH-1:0]        gain,
    input  logic signed [GAIN_WIDTH-1:0] offset,
    output logic [DAC_WIDTH-1:0]         code_data,
    output logic                         code_valid,
    input  logic                         code_ready
);

    localparam int PROD_WIDTH = WORD_WIDTH + GAIN_WIDTH + 1;
    // Drops the Q1.13 fraction and the sample bits below the DAC resolution.
    localparam int SHIFT      = (GAIN_WIDTH - 1) + (WORD_WIDTH - DAC_WIDTH);
    localparam int MID_CODE   = 2 ** (DAC_WIDTH - 1);
    localparam int MAX_CODE   = 2 ** DAC_WIDTH - 1;

    logic signed [PROD_WIDTH-1:0] prod_s1;
    logic                         valid_s1;
    logic signed [PROD_WIDTH:0]   sum_c;
    logic [DAC_WIDTH-1:0]         code_c;
    logic                         adv_s1;
    logic                         adv_s2;

    assign adv_s2    = !code_valid || code_ready;
    assign adv_s1    = !valid_s1 || adv_s2;
    assign smp_ready = adv_s1;

    // Signed sample times unsigned gain, shifted back to DAC scale and
    // moved to offset binary.
    assign sum_c = (prod_s1 >>> SHIFT) + offset + MID_CODE;

    always_comb begin
        if (sum_c < 0) begin
            code_c = '0;
        end else if (sum_c > MAX_CODE) begin
            code_c = '1;
        end else begin
            code_c = sum_c[DAC_WIDTH-1:0];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_s1   <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            if (adv_s1) begin
                valid_s1 <= smp_valid;
            end
            if (adv_s2) begin
                code_valid <= valid_s1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (adv_s1 && smp_valid) begin
            prod_s1 <= smp_data * $signed({1'b0, gain});
        end
        if (adv_s2 && valid_s1) begin
            code_data <= code_c;
        end
    end

endmodule

`default_nettype wire

// ==== design/ad7390_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ad7390_serializer
    import dac_pkg::*;
#(
    parameter int CLK_DIV   = 4,
    parameter int DAC_WIDTH = 12
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic [DAC_WIDTH-1:0] code_data,
    input  logic                 code_valid,
    output logic                 code_ready,
    input  logic                 clr_req,
    output logic                 dac_clk,
    output logic                 dac_sdi,
    output logic                 dac_ld,
    output logic                 dac_clr
);

    localparam int BIT_WIDTH = $clog2(DAC_WIDTH);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SHIFT = 2'd1;
    localparam logic [1:0] ST_LOAD  = 2'd2;
    localparam logic [1:0] ST_CLEAR = 2'd3;

    logic [1:0]            state;
    logic [WORD_WIDTH-1:0] div_cnt;
    logic                  half_clk;
    logic                  tick;
    logic [DAC_WIDTH-1:0]  shift_reg;
    logic [BIT_WIDTH-1:0]  bit_cnt;
    logic                  clr_pend;
    logic                  accept;
    logic                  clr_start;

    assign tick      = (div_cnt == CLK_DIV);
    assign accept    = (state == ST_IDLE) && code_ready && code_valid;
    // A code already handed over wins over a waiting clear.
    assign clr_start = (state == ST_IDLE) && !accept && clr_pend;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= ST_IDLE;
            div_cnt    <= '0;
            half_clk   <= 1'b0;
            bit_cnt    <= '0;
            clr_pend   <= 1'b0;
            code_ready <= 1'b0;
            dac_clk    <= 1'b0;
            dac_sdi    <= 1'b0;
            dac_ld     <= 1'b1;
            dac_clr    <= 1'b1;
        end else begin
            if (tick) begin
                div_cnt  <= '0;
                half_clk <= ~half_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (clr_req) begin
                clr_pend <= 1'b1;
            end else if (clr_start) begin
                clr_pend <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        // Restart the divider so every frame has the same shape.
                        code_ready <= 1'b0;
                        dac_sdi    <= code_data[DAC_WIDTH-1];
                        bit_cnt    <= BIT_WIDTH'(DAC_WIDTH - 1);
                        div_cnt    <= '0;
                        half_clk   <= 1'b0;
                        state      <= ST_SHIFT;
                    end else if (clr_start) begin
                        code_ready <= 1'b0;
                        dac_clr    <= 1'b0;
                        div_cnt    <= '0;
                        state      <= ST_CLEAR;
                    end else begin
                        code_ready <= 1'b1;
                    end
                end
                ST_SHIFT: begin
                    if (tick) begin
                        dac_clk <= ~half_clk;
                        // Data moves only on the falling edge of dac_clk.
                        if (half_clk) begin
                            if (bit_cnt == '0) begin
                                dac_sdi <= 1'b0;
                                dac_ld  <= 1'b0;
                                state   <= ST_LOAD;
                            end else begin
                                dac_sdi <= shift_reg[DAC_WIDTH-1];
                                bit_cnt <= bit_cnt - 1'b1;
                            end
                        end
                    end
                end
                ST_LOAD: begin
                    if (tick) begin
                        dac_ld <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                ST_CLEAR: begin
                    if (tick) begin
                        dac_clr <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Bits still to send after the one on dac_sdi, MSB first.
    always_ff @(posedge aclk) begin
        if (accept) begin
            shift_reg <= {code_data[DAC_WIDTH-2:0], 1'b0};
        end else if (state == ST_SHIFT && tick && half_clk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

`default_nettype wire

// ==== design/dac_channel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_channel_top
    import dac_pkg::*;
#(
    parameter int CLK_DIV    = 4,
    parameter int DAC_WIDTH  = 12,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic [WORD_WIDTH-1:0] s_tdata,
    input  logic                  s_tuser,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    output logic                  dac_clk,
    output logic                  dac_sdi,
    output logic                  dac_ld,
    output logic                  dac_clr
);

    logic signed [WORD_WIDTH-1:0] smp_data;
    logic                         smp_valid;
    logic                         smp_ready;
    logic [GAIN_WIDTH-1:0]        gain;
    logic signed [GAIN_WIDTH-1:0] offset;
    logic                         clr_req;
    logic [DAC_WIDTH-1:0]         code_data;
    logic                         code_valid;
    logic                         code_ready;

    dac_cmd_decoder #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_decoder (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_tdata   (s_tdata),
        .s_tuser   (s_tuser),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .smp_data  (smp_data),
        .smp_valid (smp_valid),
        .smp_ready (smp_ready),
        .gain      (gain),
        .offset    (offset),
        .clr_req   (clr_req)
    );

    dac_scaler #(
        .DAC_WIDTH (DAC_WIDTH)
    ) u_scaler (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .smp_data   (smp_data),
        .smp_valid  (smp_valid),
        .smp_ready  (smp_ready),
        .gain       (gain),
        .offset     (offset),
        .code_data  (code_data),
        .code_valid (code_valid),
        .code_ready (code_ready)
    );

    ad7390_serializer #(
        .CLK_DIV   (CLK_DIV),
        .DAC_WIDTH (DAC_WIDTH)
    ) u_serializer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .code_data  (code_data),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .clr_req    (clr_req),
        .dac_clk    (dac_clk),
        .dac_sdi    (dac_sdi),
        .dac_ld     (dac_ld),
        .dac_clr    (dac_clr)
    );

endmodule

`default_nettype wire

// ==== sim/dac_channel_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_channel_assert (
    input logic aclk,
    input logic aresetn,
    input logic dac_clk,
    input logic dac_sdi,
    input logic dac_ld,
    input logic dac_clr
);

    // The DAC samples on the rising edge, so data may only move while the clock is low.
    a_sdi_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        dac_clk |-> $stable(dac_sdi)
    ) else $error("dac_sdi changed while dac_clk was high");

    a_ld_clr_apart: assert property (
        @(posedge aclk) disable iff (!aresetn)
        dac_ld || dac_clr
    ) else $error("dac_ld and dac_clr were low together");

    a_clk_low_in_load: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !dac_ld |-> !dac_clk
    ) else $error("dac_clk was high during the load strobe");

endmodule

bind ad7390_serializer dac_channel_assert u_pin_assert (
    .aclk    (aclk),
    .aresetn (aresetn),
    .dac_clk (dac_clk),
    .dac_sdi (dac_sdi),
    .dac_ld  (dac_ld),
    .dac_clr (dac_clr)
);

`default_nettype wire

// ==== sim/tb_dac_channel.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dac_channel
    import dac_pkg::*;
();

    localparam int CLK_DIV        = 2;
    localparam int DAC_WIDTH      = 12;
    localparam int FIFO_DEPTH     = 4;
    // One frame plus its load period, in aclk cycles.
    localparam int FRAME_CYCLES   = 2 * (DAC_WIDTH + 1) * (CLK_DIV + 1);
    localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES;

    logic                  aclk;
    logic                  aresetn;
    logic [WORD_WIDTH-1:0] s_tdata;
    logic                  s_tuser;
    logic                  s_tvalid;
    logic                  s_tready;
    logic                  dac_clk;
    logic                  dac_sdi;
    logic                  dac_ld;
    logic                  dac_clr;

    integer               seed;
    int                   cur_gain;
    int                   cur_offset;
    logic                 saw_full;
    int                   cycles     = 0;
    int                   clr_pulses = 0;
    int                   ld_in_clr  = 0;
    int                   bit_count  = 0;
    logic                 prev_clk   = 1'b0;
    logic                 prev_ld    = 1'b1;
    logic                 prev_clr   = 1'b1;
    logic [DAC_WIDTH-1:0] cap_shift  = '0;
    logic [DAC_WIDTH-1:0] cap_q[$];
    logic [DAC_WIDTH-1:0] exp_q[$];

    dac_channel_top #(
        .CLK_DIV    (CLK_DIV),
        .DAC_WIDTH  (DAC_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dac_channel_top (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .dac_clk  (dac_clk),
        .dac_sdi  (dac_sdi),
        .dac_ld   (dac_ld),
        .dac_clr  (dac_clr)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // The pins change on rising aclk edges, so the falling edge sees them settled.
    always @(negedge aclk) begin
        if (aresetn) begin
            if (dac_clk && !prev_clk) begin
                cap_shift <= {cap_shift[DAC_WIDTH-2:0], dac_sdi};
                bit_count <= bit_count + 1;
            end
            if (!dac_ld && prev_ld) begin
                check_value("frame bits", bit_count, DAC_WIDTH);
                cap_q.push_back(cap_shift);
                bit_count <= 0;
            end
            if (!dac_clr && prev_clr) begin
                clr_pulses <= clr_pulses + 1;
            end
            if (!dac_ld && !dac_clr) begin
                ld_in_clr <= 1;
            end
        end
        prev_clk <= dac_clk;
        prev_ld  <= dac_ld;
        prev_clr <= dac_clr;
    end

    // Gain is Q1.13 and the 16-bit sample drops 4 bits, hence the shift by 17.
    function automatic logic [DAC_WIDTH-1:0] model_code(input int sample, input int g,
                                                        input int off);
        int v;
        v = ((sample * g) >>> 17) + off + 2048;
        if (v < 0) begin
            v = 0;
        end else if (v > 4095) begin
            v = 4095;
        end
        return v[DAC_WIDTH-1:0];
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic send_word(input logic [WORD_WIDTH-1:0] data, input logic user);
        s_tdata  = data;
        s_tuser  = user;
        s_tvalid = 1'b1;
        while (!s_tready) begin
            saw_full = 1'b1;
            wait_cycles(1);
        end
        wait_cycles(1);
        s_tvalid = 1'b0;
    endtask

    task automatic send_sample(input logic signed [WORD_WIDTH-1:0] sample);
        dac_word_u w;
        w.sample = sample;
        exp_q.push_back(model_code(sample, cur_gain, cur_offset));
        send_word(w, 1'b0);
    endtask

    task automatic send_ctrl(input dac_op_e op, input logic [GAIN_WIDTH-1:0] value);
        dac_word_u w;
        w.ctrl.op    = op;
        w.ctrl.value = value;
        case (op)
            op_set_gain:   cur_gain = int'(value);
            op_set_offset: cur_offset = int'($signed(value));
            default:       begin end
        endcase
        send_word(w, 1'b1);
    endtask

    task automatic expect_code(input logic [DAC_WIDTH-1:0] expected);
        logic [DAC_WIDTH-1:0] got;
        while (cap_q.size() == 0) begin
            wait_cycles(1);
        end
        got = cap_q.pop_front();
        check_value("dac code", got, expected);
    endtask

    task automatic check_expected();
        while (exp_q.size() > 0) begin
            expect_code(exp_q.pop_front());
        end
    endtask

    task automatic apply_reset();
        aresetn = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        check_value("dac_ld", dac_ld, 1);
        check_value("dac_clr", dac_clr, 1);
        check_value("dac_clk", dac_clk, 0);
        wait_cycles(2);
        check_value("s_tready", s_tready, 1);
    endtask

    task automatic unity_gain_samples();
        int smp;
        send_sample(16'sd0);
        send_sample(16'sd32767);
        send_sample(16'h8000);
        repeat (16) begin
            smp = $random(seed);
            send_sample(smp[15:0]);
        end
        check_expected();
    endtask

    task automatic gain_offset_samples();
        send_ctrl(op_set_gain, GAIN_WIDTH'(GAIN_UNITY / 2));
        send_sample(16'sd20000);
        check_expected();
        send_ctrl(op_set_offset, 14'd100);
        send_sample(16'sd32767);
        send_sample(-16'sd12345);
        check_expected();
        send_ctrl(op_set_offset, 14'(-300));
        send_sample(16'sd4000);
        send_sample(16'h8000);
        check_expected();
        // Nearly twice unity gain pushes full-scale samples past both rails.
        send_ctrl(op_set_offset, 14'd0);
        send_ctrl(op_set_gain, 14'h3fff);
        send_sample(16'sd32767);
        send_sample(16'h8000);
        check_expected();
        send_ctrl(op_set_gain, GAIN_WIDTH'(GAIN_UNITY));
    endtask

    task automatic burst_back_pressure();
        int i;
        saw_full = 1'b0;
        for (i = 0; i < 10; i++) begin
            send_sample(16'(i * 3001 - 15000));
        end
        check_value("s_tready low seen", saw_full, 1);
        check_expected();
    endtask

    task automatic clear_between_frames();
        int pulses_before;
        wait_cycles(FRAME_CYCLES / 4);
        check_value("captured queue size", cap_q.size(), 0);
        pulses_before = clr_pulses;
        send_ctrl(op_clear, 14'd0);
        while (clr_pulses == pulses_before || !dac_clr) begin
            wait_cycles(1);
        end
        wait_cycles(FRAME_CYCLES / 4);
        check_value("dac_clr pulses", clr_pulses - pulses_before, 1);
        check_value("dac_ld low during clear", ld_in_clr, 0);
        check_value("captured queue size", cap_q.size(), 0);
        send_sample(16'sd10000);
        check_expected();
    endtask

    // A nonzero value shows up in the code if it lands in the gain or the offset.
    task automatic ignored_command();
        int pulses_before;
        pulses_before = clr_pulses;
        send_ctrl(op_none, 14'd1000);
        send_sample(16'sd12000);
        check_expected();
        check_value("dac_clr pulses", clr_pulses - pulses_before, 0);
    endtask

    initial begin
        seed       = 32'h57c4;
        aresetn    = 1'b0;
        s_tdata    = '0;
        s_tuser    = 1'b0;
        s_tvalid   = 1'b0;
        saw_full   = 1'b0;
        cur_gain   = GAIN_UNITY;
        cur_offset = 0;
        apply_reset();
        unity_gain_samples();
        gain_offset_samples();
        burst_back_pressure();
        clear_between_frames();
        ignored_command();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/dac_pkg.sv
design/dac_cmd_decoder.sv
design/dac_scaler.sv
design/ad7390_serializer.sv
design/dac_channel_top.sv
sim/dac_channel_assert.sv
sim/tb_dac_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DAC channel testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dac_channel \
    -f project.f \
    -Mdir obj_dir

# The simulator status is not trusted on its own; the log decides.
./obj_dir/Vtb_dac_channel | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
